// ==== rtl/calc_pkg.sv ====
`default_nettype none

package calc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath widths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int OPERAND_W  = 16;
    localparam int DIGIT_W    = 4;
    localparam int NUM_SLICES = OPERAND_W / DIGIT_W;  // Four slices.

    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [DIGIT_W-1:0]   digit_t;
    typedef logic [7:0]           cycles_t;

    // Operation codes. Code 11 falls back to add.
    typedef logic [1:0] op_t;
    localparam op_t OP_ADD  = 2'b00;
    localparam op_t OP_SUB  = 2'b01;   // A - B.
    localparam op_t OP_RSUB = 2'b10;   // B - A.

    localparam logic MODE_RIPPLE    = 1'b0;
    localparam logic MODE_LOOKAHEAD = 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencer states.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        ST_INIT    = 3'd0,
        ST_DATA_IN = 3'd1,
        ST_BUSY    = 3'd2,
        ST_DONE    = 3'd3,
        ST_DISPLAY = 3'd4
    } calc_state_t;

endpackage

`default_nettype wire

// ==== rtl/regmap_pkg.sv ====
`default_nettype none

package regmap_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Register offsets.
    localparam addr_t REG_OPA    = 8'h00;
    localparam addr_t REG_OPB    = 8'h04;
    localparam addr_t REG_CTRL   = 8'h08;  // Write only.
    localparam addr_t REG_STATUS = 8'h0C;
    localparam addr_t REG_RESULT = 8'h10;
    localparam addr_t REG_CYCLES = 8'h14;

    // CTRL fields.
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_CLEAR_BIT = 1;
    localparam int CTRL_OP_LSB    = 2;     // Two bits wide.
    localparam int CTRL_MODE_BIT  = 4;

    // STATUS fields, state sits in the low bits.
    localparam int STATUS_CARRY_BIT = 4;
    localparam int STATUS_OVF_BIT   = 5;

endpackage

`default_nettype wire

// ==== rtl/apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  regmap_pkg::addr_t     paddr,
    input  regmap_pkg::data_t     pwdata,
    output regmap_pkg::data_t     prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  input_en,
    input  calc_pkg::calc_state_t state,
    input  calc_pkg::operand_t    result,
    input  logic                  carry,
    input  logic                  overflow,
    input  calc_pkg::cycles_t     cycles,
    output calc_pkg::operand_t    opa,
    output calc_pkg::operand_t    opb,
    output calc_pkg::op_t         op,
    output logic                  mode,
    output logic                  start,
    output logic                  clear
);
    import calc_pkg::*;
    import regmap_pkg::*;

    logic access;       // Access phase of a transfer.
    logic wr_access;
    logic opnd_hit;
    logic ro_hit;
    logic mapped;
    logic err;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode and error flag.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign opnd_hit = (paddr == REG_OPA) || (paddr == REG_OPB);
    assign ro_hit   = (paddr == REG_STATUS) || (paddr == REG_RESULT) ||
                      (paddr == REG_CYCLES);
    assign mapped   = opnd_hit || ro_hit || (paddr == REG_CTRL);

    assign err = !mapped ||
                 (pwrite && ro_hit) ||
                 (pwrite && opnd_hit && !input_en);  // Operands locked.

    assign pready  = 1'b1;             // No wait states.
    assign pslverr = access && err;

    // Register writes. Start and clear pulse one cycle later.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opa   <= '0;
            opb   <= '0;
            op    <= OP_ADD;
            mode  <= MODE_RIPPLE;
            start <= 1'b0;
            clear <= 1'b0;
        end else begin
            start <= 1'b0;
            clear <= 1'b0;
            if (wr_access && !err) begin
                case (paddr)
                    REG_OPA: opa <= pwdata[OPERAND_W-1:0];
                    REG_OPB: opb <= pwdata[OPERAND_W-1:0];
                    REG_CTRL: begin
                        op    <= pwdata[CTRL_OP_LSB +: $bits(op_t)];
                        mode  <= pwdata[CTRL_MODE_BIT];
                        clear <= pwdata[CTRL_CLEAR_BIT];
                        start <= pwdata[CTRL_START_BIT];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read mux.
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                REG_OPA:    prdata[OPERAND_W-1:0] = opa;
                REG_OPB:    prdata[OPERAND_W-1:0] = opb;
                REG_STATUS: begin
                    prdata[$bits(calc_state_t)-1:0] = state;  // Live state.
                    prdata[STATUS_CARRY_BIT]         = carry;
                    prdata[STATUS_OVF_BIT]           = overflow;
                end
                REG_RESULT: prdata[OPERAND_W-1:0]       = result;
                REG_CYCLES: prdata[$bits(cycles_t)-1:0] = cycles;
                default:    prdata = '0;
            endcase
        end
    end

    a_start_clear_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(start && clear)
    ) else $error("start and clear pulsed together");

endmodule

`default_nettype wire

// ==== rtl/calc_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module calc_control (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  clear,
    input  logic                  comp_ready,
    output logic                  input_en,
    output logic                  load,
    output logic                  hold,
    output calc_pkg::calc_state_t state
);
    import calc_pkg::*;

    calc_state_t state_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_next = state;
        case (state)
            ST_INIT: begin
                state_next = ST_DATA_IN;
            end
            ST_DATA_IN: begin
                if (start) begin
                    state_next = ST_BUSY;
                end
            end
            ST_BUSY: begin
                if (comp_ready) begin      // Slices finished.
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                state_next = ST_DISPLAY;
            end
            ST_DISPLAY: begin
                if (clear) begin
                    state_next = ST_INIT;
                end
            end
            default: begin
                state_next = ST_INIT;      // Illegal code recovers.
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_INIT;
            load  <= 1'b0;
        end else begin
            state <= state_next;
            load  <= (state == ST_DATA_IN) && start;  // First BUSY cycle.
        end
    end

    // Output decode.
    assign input_en = (state == ST_DATA_IN);
    assign hold     = (state == ST_DONE);      // Collector latches result.

    a_ready_in_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        comp_ready |-> (state == ST_BUSY)
    ) else $error("comp_ready outside ST_BUSY");

endmodule

`default_nettype wire

// ==== rtl/operand_splitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_splitter (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        load,
    input  calc_pkg::operand_t                          opa,
    input  calc_pkg::operand_t                          opb,
    input  calc_pkg::op_t                               op,
    output calc_pkg::digit_t [calc_pkg::NUM_SLICES-1:0] a_digits,
    output calc_pkg::digit_t [calc_pkg::NUM_SLICES-1:0] b_digits,
    output logic                                        carry_in0
);
    import calc_pkg::*;

    operand_t a_q;
    operand_t b_q;

    // Subtraction as two's complement, invert one side and carry in.
    always_ff @(posedge clk) begin
        if (load) begin
            case (op)
                OP_SUB: begin
                    a_q <= opa;
                    b_q <= ~opb;
                end
                OP_RSUB: begin
                    a_q <= opb;
                    b_q <= ~opa;
                end
                default: begin             // OP_ADD and code 11.
                    a_q <= opa;
                    b_q <= opb;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            carry_in0 <= 1'b0;
        end else if (load) begin
            carry_in0 <= (op == OP_SUB) || (op == OP_RSUB);
        end
    end

    assign a_digits = a_q;   // Digit i is bits 4i+3..4i.
    assign b_digits = b_q;

endmodule

`default_nettype wire

// ==== rtl/adder_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module adder_slice (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en,
    input  calc_pkg::digit_t a,
    input  calc_pkg::digit_t b,
    input  logic             cin,
    output calc_pkg::digit_t sum,
    output logic             cout,
    output logic             gen,
    output logic             prop,
    output logic             msb_cin
);
    import calc_pkg::*;

    digit_t             p;
    digit_t             g;
    logic [DIGIT_W:0]   c;     // Internal carries, c[0] is cin.
    logic               gg;

    always_comb begin
        p    = a ^ b;
        g    = a & b;
        c[0] = cin;
        gg   = 1'b0;
        for (int i = 0; i < DIGIT_W; i++) begin
            c[i+1] = g[i] | (p[i] & c[i]);
            gg     = g[i] | (p[i] & gg);   // Group generate, cin forced low.
        end
    end

    assign cout    = c[DIGIT_W];
    assign msb_cin = c[DIGIT_W-1];  // Carry into the sign bit.
    assign gen     = gg;
    assign prop    = &p;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
        end else if (en) begin
            sum <= p ^ c[DIGIT_W-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/result_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_collector (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        load,
    input  logic                                        hold,
    input  logic                                        mode,
    input  logic                                        carry_in0,
    input  calc_pkg::digit_t [calc_pkg::NUM_SLICES-1:0] sums,
    input  logic [calc_pkg::NUM_SLICES-1:0]             couts,
    input  logic [calc_pkg::NUM_SLICES-1:0]             gens,
    input  logic [calc_pkg::NUM_SLICES-1:0]             props,
    input  logic                                        top_msb_cin,
    output logic [calc_pkg::NUM_SLICES-1:0]             cins,
    output logic [calc_pkg::NUM_SLICES-1:0]             slice_en,
    output logic                                        comp_ready,
    output calc_pkg::operand_t                          result,
    output logic                                        carry,
    output logic                                        overflow,
    output calc_pkg::cycles_t                           cycles
);
    import calc_pkg::*;

    logic                  active;   // Computation in flight.
    logic                  lookahead;
    logic                  mode_q;
    logic [NUM_SLICES-1:0] la_c;     // Lookahead carries.
    logic [NUM_SLICES-1:1] carry_q;  // Registered ripple carries.

    assign lookahead = (mode_q == MODE_LOOKAHEAD);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Carry selection and slice enables.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        la_c[0] = carry_in0;
        cins[0] = carry_in0;
        for (int i = 1; i < NUM_SLICES; i++) begin
            la_c[i] = gens[i-1] | (props[i-1] & la_c[i-1]);
            cins[i] = lookahead ? la_c[i] : carry_q[i];
        end
        // Ripple steps through the slices, counter doubles as index.
        for (int i = 0; i < NUM_SLICES; i++) begin
            slice_en[i] = active && (lookahead || (cycles == cycles_t'(i)));
        end
    end

    assign comp_ready = active &&
                        (lookahead || (cycles == cycles_t'(NUM_SLICES - 1)));

    always_ff @(posedge clk) begin
        for (int i = 1; i < NUM_SLICES; i++) begin
            if (slice_en[i-1]) begin
                carry_q[i] <= couts[i-1];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            mode_q <= MODE_RIPPLE;
            cycles <= '0;
        end else if (load) begin
            active <= 1'b1;
            mode_q <= mode;
            cycles <= '0;
        end else if (active) begin
            cycles <= cycles + 1'b1;
            if (comp_ready) begin
                active <= 1'b0;
            end
        end
    end

    // Result and flags, slice inputs are still stable here.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result   <= '0;
            carry    <= 1'b0;
            overflow <= 1'b0;
        end else if (hold) begin
            result   <= sums;
            carry    <= couts[NUM_SLICES-1];
            overflow <= couts[NUM_SLICES-1] ^ top_msb_cin;
        end
    end

    a_no_en_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (load || hold) |-> (slice_en == '0)
    ) else $error("slice enabled outside a computation");

endmodule

`default_nettype wire

// ==== rtl/calc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module calc_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  regmap_pkg::addr_t paddr,
    input  regmap_pkg::data_t pwdata,
    output regmap_pkg::data_t prdata,
    output logic              pready,
    output logic              pslverr
);
    import calc_pkg::*;

    // Register block to core.
    operand_t    opa;
    operand_t    opb;
    op_t         op;
    logic        mode;
    logic        start;
    logic        clear;

    // Sequencer.
    logic        input_en;
    logic        load;
    logic        hold;
    logic        comp_ready;
    calc_state_t state;

    // Slice array.
    digit_t [NUM_SLICES-1:0] a_digits;
    digit_t [NUM_SLICES-1:0] b_digits;
    digit_t [NUM_SLICES-1:0] sums;
    logic                    carry_in0;
    logic [NUM_SLICES-1:0]   cins;
    logic [NUM_SLICES-1:0]   slice_en;
    logic [NUM_SLICES-1:0]   couts;
    logic [NUM_SLICES-1:0]   gens;
    logic [NUM_SLICES-1:0]   props;
    logic [NUM_SLICES-1:0]   msb_cins;

    operand_t    result;
    logic        carry;
    logic        overflow;
    cycles_t     cycles;

    apb_regs apb_regs_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .input_en (input_en),
        .state    (state),
        .result   (result),
        .carry    (carry),
        .overflow (overflow),
        .cycles   (cycles),
        .opa      (opa),
        .opb      (opb),
        .op       (op),
        .mode     (mode),
        .start    (start),
        .clear    (clear)
    );

    calc_control calc_control_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .clear      (clear),
        .comp_ready (comp_ready),
        .input_en   (input_en),
        .load       (load),
        .hold       (hold),
        .state      (state)
    );

    operand_splitter operand_splitter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .opa       (opa),
        .opb       (opb),
        .op        (op),
        .a_digits  (a_digits),
        .b_digits  (b_digits),
        .carry_in0 (carry_in0)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Adder slices, slice 0 holds the low digit.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
        adder_slice adder_slice_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .en      (slice_en[i]),
            .a       (a_digits[i]),
            .b       (b_digits[i]),
            .cin     (cins[i]),
            .sum     (sums[i]),
            .cout    (couts[i]),
            .gen     (gens[i]),
            .prop    (props[i]),
            .msb_cin (msb_cins[i])
        );
    end

    result_collector result_collector_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load),
        .hold        (hold),
        .mode        (mode),
        .carry_in0   (carry_in0),
        .sums        (sums),
        .couts       (couts),
        .gens        (gens),
        .props       (props),
        .top_msb_cin (msb_cins[NUM_SLICES-1]),  // Overflow needs the top slice only.
        .cins        (cins),
        .slice_en    (slice_en),
        .comp_ready  (comp_ready),
        .result      (result),
        .carry       (carry),
        .overflow    (overflow),
        .cycles      (cycles)
    );

endmodule

`default_nettype wire

// ==== testbench/calc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module calc_tb;
    import calc_pkg::*;
    import regmap_pkg::*;

    localparam int    CYCLE_LIMIT = 4000;
    localparam int    POLL_LIMIT  = 20;
    localparam int    NUM_RANDOM  = 42;
    localparam addr_t UNMAPPED    = 8'h20;

    logic  clk;
    logic  rst_n;
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    data_t pwdata;
    data_t prdata;
    logic  pready;
    logic  pslverr;

    // Reference model state.
    logic        err_exp;      // Expected pslverr of the current transfer.
    logic        chk_en;       // Read data is checked.
    calc_state_t exp_state;
    operand_t    exp_result;
    logic        exp_carry;
    logic        exp_ovf;
    cycles_t     exp_cycles;
    operand_t    cur_a;
    operand_t    cur_b;
    logic        rd_access;
    int          cycle_count = 0;

    calc_top calc_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the run did not finish.", CYCLE_LIMIT);
            $display("Regression failed");
            $fatal(1);
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks on every APB access phase.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rd_access = psel && penable && !pwrite && chk_en;

    a_pready: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable) |-> pready)
        else stop_on_error("APB access phase saw pready low.");

    a_pslverr: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable) |-> (pslverr == err_exp))
        else stop_on_error($sformatf("FAIL pslverr at paddr 0x%02h: got 0x%0h, expected 0x%0h",
            $sampled(paddr), $sampled(pslverr), $sampled(err_exp)));

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_access && paddr == REG_RESULT) |-> (prdata == data_t'(exp_result)))
        else stop_on_error($sformatf("FAIL result: got 0x%08h, expected 0x%04h",
            $sampled(prdata), exp_result));

    a_cycles: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_access && paddr == REG_CYCLES) |-> (prdata == data_t'(exp_cycles)))
        else stop_on_error($sformatf("FAIL cycles: got 0x%08h, expected 0x%02h",
            $sampled(prdata), exp_cycles));

    a_state: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_access && paddr == REG_STATUS) |-> (prdata[2:0] == exp_state))
        else stop_on_error($sformatf("FAIL state: got 0x%0h, expected 0x%0h",
            $sampled(prdata[2:0]), exp_state));

    a_carry: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_access && paddr == REG_STATUS) |-> (prdata[STATUS_CARRY_BIT] == exp_carry))
        else stop_on_error($sformatf("FAIL carry: got 0x%0h, expected 0x%0h",
            $sampled(prdata[STATUS_CARRY_BIT]), exp_carry));

    a_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_access && paddr == REG_STATUS) |-> (prdata[STATUS_OVF_BIT] == exp_ovf))
        else stop_on_error($sformatf("FAIL overflow: got 0x%0h, expected 0x%0h",
            $sampled(prdata[STATUS_OVF_BIT]), exp_ovf));

    // Returns {overflow, carry, result} from integer arithmetic.
    function automatic logic [17:0] model_calc(input operand_t a, input operand_t b,
                                               input op_t code);
        int       ua;
        int       ub;
        int       sres;
        logic     carry_bit;
        logic     ovf_bit;
        operand_t res;
        ua = int'(a);
        ub = int'(b);
        case (code)
            OP_SUB: begin
                sres      = int'($signed(a)) - int'($signed(b));
                carry_bit = (ua >= ub);            // No borrow.
                res       = operand_t'(ua - ub);
            end
            OP_RSUB: begin
                sres      = int'($signed(b)) - int'($signed(a));
                carry_bit = (ub >= ua);
                res       = operand_t'(ub - ua);
            end
            default: begin
                sres      = int'($signed(a)) + int'($signed(b));
                carry_bit = ((ua + ub) > 65535);
                res       = operand_t'(ua + ub);
            end
        endcase
        ovf_bit = (sres > 32767) || (sres < -32768);
        return {ovf_bit, carry_bit, res};
    endfunction

    function automatic data_t ctrl_word(input op_t code, input logic adder_mode,
                                        input logic go, input logic clr);
        data_t w;
        w = '0;
        w[CTRL_OP_LSB +: 2]  = code;
        w[CTRL_MODE_BIT]     = adder_mode;
        w[CTRL_START_BIT]    = go;
        w[CTRL_CLEAR_BIT]    = clr;
        return w;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB transfers and test steps.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic write_reg(input addr_t addr, input data_t data, input logic expect_err);
        @(posedge clk);
        psel    <= 1'b1;    // Setup phase.
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        err_exp <= expect_err;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic read_reg(input addr_t addr, input logic check, input logic expect_err,
                            output data_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        err_exp <= expect_err;
        chk_en  <= check;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;      // Mid access phase.
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        chk_en  <= 1'b0;
    endtask

    task automatic wait_display();
        data_t st;
        int    polls;
        polls = 0;
        st    = '0;
        while (st[2:0] != ST_DISPLAY) begin
            if (polls == POLL_LIMIT) begin
                stop_on_error("Sequencer did not reach ST_DISPLAY in time.");
            end else begin
                read_reg(REG_STATUS, 1'b0, 1'b0, st);
                polls++;
            end
        end
    endtask

    task automatic check_outcome();
        data_t rd;
        read_reg(REG_STATUS, 1'b1, 1'b0, rd);
        read_reg(REG_RESULT, 1'b1, 1'b0, rd);
        read_reg(REG_CYCLES, 1'b1, 1'b0, rd);
    endtask

    task automatic set_operands(input operand_t a, input operand_t b);
        write_reg(REG_OPA, data_t'(a), 1'b0);
        write_reg(REG_OPB, data_t'(b), 1'b0);
        cur_a = a;
        cur_b = b;
    endtask

    task automatic start_calc(input op_t code, input logic adder_mode);
        write_reg(REG_CTRL, ctrl_word(code, adder_mode, 1'b1, 1'b0), 1'b0);
        {exp_ovf, exp_carry, exp_result} = model_calc(cur_a, cur_b, code);
        exp_cycles = (adder_mode == MODE_LOOKAHEAD) ? 8'd1 : 8'd4;
        exp_state  = ST_DISPLAY;
        wait_display();
        check_outcome();
    endtask

    task automatic clear_calc();
        data_t rd;
        write_reg(REG_CTRL, ctrl_word(OP_ADD, MODE_RIPPLE, 1'b0, 1'b1), 1'b0);
        exp_state = ST_DATA_IN;
        read_reg(REG_STATUS, 1'b1, 1'b0, rd);
    endtask

    task automatic run_calc(input operand_t a, input operand_t b, input op_t code,
                            input logic adder_mode);
        set_operands(a, b);
        start_calc(code, adder_mode);
        clear_calc();
    endtask

    initial begin
        data_t       rd;
        int unsigned seed_val;
        clk        = 1'b0;
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        err_exp    = 1'b0;
        chk_en     = 1'b0;
        exp_state  = ST_DATA_IN;
        exp_result = '0;
        exp_carry  = 1'b0;
        exp_ovf    = 1'b0;
        exp_cycles = '0;
        cur_a      = '0;
        cur_b      = '0;
        seed_val   = $urandom(90271);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        check_outcome();   // Reset values and ST_DATA_IN.

        for (int i = 0; i < NUM_RANDOM; i++) begin
            run_calc(operand_t'($urandom), operand_t'($urandom), op_t'(i % 3), 1'((i / 3) % 2));
        end
        run_calc(16'h1234, 16'hF00D, 2'b11, MODE_RIPPLE);   // Code 11 adds.

        // Edge operands in both modes.
        run_calc(16'hFFFF, 16'h0001, OP_ADD, MODE_RIPPLE);
        run_calc(16'hFFFF, 16'h0001, OP_ADD, MODE_LOOKAHEAD);
        run_calc(16'h7FFF, 16'h0001, OP_ADD, MODE_RIPPLE);
        run_calc(16'h7FFF, 16'h0001, OP_ADD, MODE_LOOKAHEAD);
        run_calc(16'h0000, 16'h0001, OP_SUB, MODE_RIPPLE);
        run_calc(16'h0000, 16'h0001, OP_SUB, MODE_LOOKAHEAD);

        // Locked operands and illegal accesses while displaying.
        set_operands(16'h0123, 16'h0456);
        start_calc(OP_ADD, MODE_LOOKAHEAD);
        write_reg(REG_OPA, 32'h0000_9999, 1'b1);
        write_reg(REG_RESULT, 32'h0000_0001, 1'b1);
        write_reg(UNMAPPED, 32'h0000_0001, 1'b1);
        read_reg(UNMAPPED, 1'b0, 1'b1, rd);
        write_reg(REG_CTRL, ctrl_word(OP_SUB, MODE_RIPPLE, 1'b1, 1'b0), 1'b0);
        check_outcome();   // Start is ignored and the result held.
        clear_calc();

        write_reg(REG_OPB, 32'h0000_0111, 1'b0);
        cur_b = 16'h0111;  // A keeps its old value.
        start_calc(OP_SUB, MODE_RIPPLE);
        clear_calc();
        write_reg(REG_STATUS, 32'h0, 1'b1);
        write_reg(REG_CYCLES, 32'h0, 1'b1);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/calc_pkg.sv
rtl/regmap_pkg.sv
rtl/apb_regs.sv
rtl/calc_control.sv
rtl/operand_splitter.sv
rtl/adder_slice.sv
rtl/result_collector.sv
rtl/calc_top.sv
testbench/calc_tb.sv
